// File: verilog/ssu_pkg.sv
// shared types and filter functions for the store set updater; imported by every design module
`default_nettype none

package ssu_pkg;

    localparam int SSID_WIDTH      = 6;
    localparam int ROB_INDEX_WIDTH = 7;

    typedef logic [SSID_WIDTH-1:0]      ssid_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

    // anything above CONF_NONE counts as a live prediction
    typedef enum logic [1:0] {
        CONF_NONE = 2'b00,
        CONF_LOW  = 2'b01,
        CONF_MID  = 2'b10,
        CONF_HIGH = 2'b11
    } conf_e;

    typedef struct packed {
        conf_e conf;
        ssid_t ssid;
    } mdp_info_t;

    // one instruction's predictor state, also the ROB update record
    typedef struct packed {
        mdp_info_t  mdp;
        rob_index_t rob_index;
    } rob_ref_t;

    typedef struct packed {
        rob_ref_t ld;
        rob_ref_t st;
    } cam_report_t;

    // slot a is the load side, slot b the store side
    typedef struct packed {
        logic     is_cam;
        logic     a_valid;
        rob_ref_t a;
        logic     b_valid;
        rob_ref_t b;
    } funnel_entry_t;

    typedef enum logic {
        STEP_A = 1'b0,
        STEP_B = 1'b1
    } resolve_step_e;

    function automatic logic has_prediction(input mdp_info_t info);
        return info.conf != CONF_NONE;
    endfunction

    // both already in the same set at full confidence
    function automatic logic is_full_match(input mdp_info_t ld, input mdp_info_t st);
        return (ld.conf == CONF_HIGH) && (st.conf == CONF_HIGH) && (ld.ssid == st.ssid);
    endfunction

    // high drops to low, everything else falls off
    function automatic conf_e decay_conf(input conf_e conf);
        return (conf == CONF_HIGH) ? CONF_LOW : CONF_NONE;
    endfunction

endpackage

`default_nettype wire

// File: verilog/update_cb.sv
// overwrite-oldest circular buffer holding reports from one source until the arbiter takes them
`timescale 1ns/1ps
`default_nettype none

module update_cb #(
    parameter int  ENTRIES = 2,
    parameter type ENTRY_T = logic [7:0]
) (
    input  logic   CLK,
    input  logic   nRST,

    input  logic   enq_valid,
    input  ENTRY_T enq_data,

    output logic   deq_valid,
    output ENTRY_T deq_data,
    input  logic   deq_ack
);

    localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int CNT_W = $clog2(ENTRIES + 1);

    ENTRY_T             mem [ENTRIES];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;
    logic               full;
    logic               drop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(ENTRIES));
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];

    // enqueue into a full buffer pushes the oldest entry out
    assign drop = enq_valid && full && !deq_ack;

    always_comb begin
        unique case ({enq_valid && !drop, deq_ack})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (deq_ack || drop)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_valid)
            mem[wr_ptr] <= enq_data;
    end

    // the arbiter only acknowledges a head it was offered
    assert property (@(posedge CLK) disable iff (!nRST) deq_ack |-> deq_valid)
        else $error("ack on empty update buffer");

endmodule

`default_nettype wire

// File: verilog/update_arbiter.sv
// fixed-priority merge of the buffered report sources into single funnel entries
`timescale 1ns/1ps
`default_nettype none

module update_arbiter import ssu_pkg::*; (
    input  logic          ldu_cam_valid,
    input  cam_report_t   ldu_cam,
    output logic          ldu_cam_ack,

    input  logic          stamofu_cam_valid,
    input  cam_report_t   stamofu_cam,
    output logic          stamofu_cam_ack,

    input  logic          ldu_commit_valid,
    input  rob_ref_t      ldu_commit,
    input  logic          stamofu_commit_valid,
    input  rob_ref_t      stamofu_commit,
    output logic          commit_ack,

    output logic          enq_valid,
    output funnel_entry_t enq_entry,
    input  logic          enq_ready
);

    function automatic funnel_entry_t cam_entry(input cam_report_t rpt);
        return '{is_cam: 1'b1, a_valid: 1'b1, a: rpt.ld, b_valid: 1'b1, b: rpt.st};
    endfunction

    always_comb begin
        ldu_cam_ack     = 1'b0;
        stamofu_cam_ack = 1'b0;
        commit_ack      = 1'b0;
        enq_valid       = 1'b0;
        enq_entry       = '0;

        if (enq_ready) begin
            if (ldu_cam_valid) begin
                ldu_cam_ack = 1'b1;
                enq_valid   = 1'b1;
                enq_entry   = cam_entry(ldu_cam);
            end else if (stamofu_cam_valid) begin
                stamofu_cam_ack = 1'b1;
                enq_valid       = 1'b1;
                enq_entry       = cam_entry(stamofu_cam);
            end else if (ldu_commit_valid || stamofu_commit_valid) begin
                // both commit heads ride in one entry
                commit_ack = 1'b1;
                enq_valid  = 1'b1;
                enq_entry  = '{is_cam: 1'b0,
                               a_valid: ldu_commit_valid, a: ldu_commit,
                               b_valid: stamofu_commit_valid, b: stamofu_commit};
            end
        end
    end

    always_comb begin
        assert ($onehot0({ldu_cam_ack, stamofu_cam_ack, commit_ack}))
            else $error("more than one source acknowledged");
    end

endmodule

`default_nettype wire

// File: verilog/funnel_queue.sv
// FIFO of merged funnel entries between the arbiter and the resolver; never overwrites
`timescale 1ns/1ps
`default_nettype none

module funnel_queue import ssu_pkg::*; #(
    parameter int ENTRIES = 2
) (
    input  logic          CLK,
    input  logic          nRST,

    input  logic          enq_valid,
    input  funnel_entry_t enq_entry,
    output logic          enq_ready,

    output logic          deq_valid,
    output funnel_entry_t deq_entry,
    input  logic          deq_pop
);

    localparam int PTR_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int CNT_W = $clog2(ENTRIES + 1);

    funnel_entry_t      mem [ENTRIES];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push      = enq_valid && enq_ready;
    assign pop       = deq_pop && deq_valid;
    assign deq_valid = (count != '0);
    assign deq_entry = mem[rd_ptr];

    always_comb begin
        unique case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    // ready comes straight off a flop, looked ahead one cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            enq_ready <= 1'b1;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count     <= count_next;
            enq_ready <= (count_next < CNT_W'(ENTRIES));
        end
    end

    always_ff @(posedge CLK) begin
        if (push)
            mem[wr_ptr] <= enq_entry;
    end

    assert property (@(posedge CLK) disable iff (!nRST) enq_valid |-> count < CNT_W'(ENTRIES))
        else $error("enqueue into full funnel");

endmodule

`default_nettype wire

// File: verilog/mdp_resolver.sv
// two-step FSM turning funnel entries into ROB predictor updates and store set table requests
`timescale 1ns/1ps
`default_nettype none

module mdp_resolver import ssu_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,

    input  logic          deq_valid,
    input  funnel_entry_t deq_entry,
    output logic          deq_pop,

    output logic          rob_update_valid,
    output rob_ref_t      rob_update,
    input  logic          rob_update_ready,

    output logic          alloc,
    input  ssid_t         new_ssid,
    output logic          touch_valid,
    output ssid_t         touch_ssid
);

    resolve_step_e step;
    resolve_step_e step_next;
    logic          send_a;
    logic          last_side;
    logic          xfer;
    logic          a_pred;
    logic          b_pred;
    logic          cam_done;
    ssid_t         chosen_ssid;
    rob_ref_t      side;

    assign a_pred = has_prediction(deq_entry.a.mdp);
    assign b_pred = has_prediction(deq_entry.b.mdp);

    // existing sets win, store side preferred when both exist
    assign chosen_ssid = b_pred ? deq_entry.b.mdp.ssid :
                         a_pred ? deq_entry.a.mdp.ssid : new_ssid;

    // ------------------------------------------------------------------------
    // side select and update payload

    // commit entries may have slot a empty, skip straight to b
    assign send_a    = (step == STEP_A) && deq_entry.a_valid;
    assign last_side = !send_a || !deq_entry.b_valid;
    assign side      = send_a ? deq_entry.a : deq_entry.b;

    assign rob_update_valid = deq_valid;
    assign xfer             = deq_valid && rob_update_ready;

    always_comb begin
        rob_update.rob_index = side.rob_index;
        if (deq_entry.is_cam) begin
            rob_update.mdp.conf = CONF_HIGH;
            rob_update.mdp.ssid = chosen_ssid;
        end else begin
            rob_update.mdp.conf = decay_conf(side.mdp.conf);
            rob_update.mdp.ssid = side.mdp.ssid;
        end
    end

    // ------------------------------------------------------------------------
    // step control and table requests

    assign deq_pop = xfer && last_side;

    always_comb begin
        step_next = step;
        if (xfer)
            step_next = last_side ? STEP_A : STEP_B;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST)
            step <= STEP_A;
        else
            step <= step_next;
    end

    // table only moves once the whole CAM entry is out
    assign cam_done    = deq_pop && deq_entry.is_cam;
    assign touch_valid = cam_done && (a_pred || b_pred);
    assign alloc       = cam_done && !(a_pred || b_pred);
    assign touch_ssid  = chosen_ssid;

    // stalled update must not change under the ROB
    assert property (@(posedge CLK) disable iff (!nRST)
        rob_update_valid && !rob_update_ready |=> rob_update_valid && $stable(rob_update))
        else $error("ROB update changed while stalled");

endmodule

`default_nettype wire

// File: verilog/store_set_table.sv
// allocation pointer handing fresh store set IDs to the resolver
`timescale 1ns/1ps
`default_nettype none

module store_set_table import ssu_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,

    input  logic  alloc,
    output ssid_t new_ssid,

    input  logic  touch_valid,
    input  ssid_t touch_ssid
);

    ssid_t alloc_ptr;

    assign new_ssid = alloc_ptr;

    // step past a set that was just used so it is not handed out again
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST)
            alloc_ptr <= '0;
        else if (alloc || (touch_valid && touch_ssid == alloc_ptr))
            alloc_ptr <= alloc_ptr + 1'b1;
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(alloc && touch_valid))
        else $error("alloc and touch in the same cycle");

endmodule

`default_nettype wire

// File: verilog/ssu_top.sv
// store set updater top level; filters incoming reports and wires buffers, arbiter, funnel and resolver
`timescale 1ns/1ps
`default_nettype none

module ssu_top import ssu_pkg::*; #(
    parameter int INPUT_ENTRIES  = 2,
    parameter int FUNNEL_ENTRIES = 2
) (
    input  logic        CLK,
    input  logic        nRST,

    input  logic        ldu_cam_valid,
    input  cam_report_t ldu_cam,
    input  logic        stamofu_cam_valid,
    input  cam_report_t stamofu_cam,
    input  logic        ldu_commit_valid,
    input  rob_ref_t    ldu_commit,
    input  logic        stamofu_commit_valid,
    input  rob_ref_t    stamofu_commit,

    output logic        rob_update_valid,
    output rob_ref_t    rob_update,
    input  logic        rob_update_ready
);

    logic          ldu_cam_enq;
    logic          stamofu_cam_enq;
    logic          ldu_commit_enq;
    logic          stamofu_commit_enq;

    logic          ldu_cam_buf_valid;
    cam_report_t   ldu_cam_buf;
    logic          ldu_cam_ack;
    logic          stamofu_cam_buf_valid;
    cam_report_t   stamofu_cam_buf;
    logic          stamofu_cam_ack;
    logic          ldu_commit_buf_valid;
    rob_ref_t      ldu_commit_buf;
    logic          stamofu_commit_buf_valid;
    rob_ref_t      stamofu_commit_buf;
    logic          commit_ack;

    logic          funnel_enq_valid;
    funnel_entry_t funnel_enq_entry;
    logic          funnel_enq_ready;
    logic          funnel_deq_valid;
    funnel_entry_t funnel_deq_entry;
    logic          funnel_deq_pop;

    logic          alloc;
    ssid_t         new_ssid;
    logic          touch_valid;
    ssid_t         touch_ssid;

    // ------------------------------------------------------------------------
    // input filters, drop reports that would change nothing

    assign ldu_cam_enq        = ldu_cam_valid && !is_full_match(ldu_cam.ld.mdp, ldu_cam.st.mdp);
    assign stamofu_cam_enq    = stamofu_cam_valid &&
                                !is_full_match(stamofu_cam.ld.mdp, stamofu_cam.st.mdp);
    assign ldu_commit_enq     = ldu_commit_valid && has_prediction(ldu_commit.mdp);
    assign stamofu_commit_enq = stamofu_commit_valid && has_prediction(stamofu_commit.mdp);

    // ------------------------------------------------------------------------
    // per-source buffers

    update_cb #(.ENTRIES(INPUT_ENTRIES), .ENTRY_T(cam_report_t)) ldu_cam_cb_i (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(ldu_cam_enq), .enq_data(ldu_cam),
        .deq_valid(ldu_cam_buf_valid), .deq_data(ldu_cam_buf),
        .deq_ack(ldu_cam_ack)
    );

    update_cb #(.ENTRIES(INPUT_ENTRIES), .ENTRY_T(cam_report_t)) stamofu_cam_cb_i (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(stamofu_cam_enq), .enq_data(stamofu_cam),
        .deq_valid(stamofu_cam_buf_valid), .deq_data(stamofu_cam_buf),
        .deq_ack(stamofu_cam_ack)
    );

    // shared commit ack only pops a buffer that had something
    update_cb #(.ENTRIES(INPUT_ENTRIES), .ENTRY_T(rob_ref_t)) ldu_commit_cb_i (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(ldu_commit_enq), .enq_data(ldu_commit),
        .deq_valid(ldu_commit_buf_valid), .deq_data(ldu_commit_buf),
        .deq_ack(commit_ack && ldu_commit_buf_valid)
    );

    update_cb #(.ENTRIES(INPUT_ENTRIES), .ENTRY_T(rob_ref_t)) stamofu_commit_cb_i (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(stamofu_commit_enq), .enq_data(stamofu_commit),
        .deq_valid(stamofu_commit_buf_valid), .deq_data(stamofu_commit_buf),
        .deq_ack(commit_ack && stamofu_commit_buf_valid)
    );

    // ------------------------------------------------------------------------
    // merge, funnel and resolve

    update_arbiter arbiter_i (
        .ldu_cam_valid(ldu_cam_buf_valid), .ldu_cam(ldu_cam_buf), .ldu_cam_ack(ldu_cam_ack),
        .stamofu_cam_valid(stamofu_cam_buf_valid), .stamofu_cam(stamofu_cam_buf),
        .stamofu_cam_ack(stamofu_cam_ack),
        .ldu_commit_valid(ldu_commit_buf_valid), .ldu_commit(ldu_commit_buf),
        .stamofu_commit_valid(stamofu_commit_buf_valid), .stamofu_commit(stamofu_commit_buf),
        .commit_ack(commit_ack),
        .enq_valid(funnel_enq_valid), .enq_entry(funnel_enq_entry),
        .enq_ready(funnel_enq_ready)
    );

    funnel_queue #(.ENTRIES(FUNNEL_ENTRIES)) funnel_i (
        .CLK(CLK), .nRST(nRST),
        .enq_valid(funnel_enq_valid), .enq_entry(funnel_enq_entry),
        .enq_ready(funnel_enq_ready),
        .deq_valid(funnel_deq_valid), .deq_entry(funnel_deq_entry),
        .deq_pop(funnel_deq_pop)
    );

    mdp_resolver resolver_i (
        .CLK(CLK), .nRST(nRST),
        .deq_valid(funnel_deq_valid), .deq_entry(funnel_deq_entry), .deq_pop(funnel_deq_pop),
        .rob_update_valid(rob_update_valid), .rob_update(rob_update),
        .rob_update_ready(rob_update_ready),
        .alloc(alloc), .new_ssid(new_ssid),
        .touch_valid(touch_valid), .touch_ssid(touch_ssid)
    );

    store_set_table sst_i (
        .CLK(CLK), .nRST(nRST),
        .alloc(alloc), .new_ssid(new_ssid),
        .touch_valid(touch_valid), .touch_ssid(touch_ssid)
    );

endmodule

`default_nettype wire

// File: bench/ssu_tb.sv
// data-driven testbench for the store set updater; replays the testdata file and checks ROB updates
`timescale 1ns/1ps
`default_nettype none

module ssu_tb import ssu_pkg::*; ();

    localparam int          INPUT_ENTRIES  = 2;
    localparam int          FUNNEL_ENTRIES = 2;
    localparam logic [31:0] LCG_SEED       = 32'hec7c127e;
    localparam int          SETTLE_CYCLES  = 8;

    // all report inputs for one cycle
    typedef struct packed {
        logic        ldu_cam_valid;
        cam_report_t ldu_cam;
        logic        stamofu_cam_valid;
        cam_report_t stamofu_cam;
        logic        ldu_commit_valid;
        rob_ref_t    ldu_commit;
        logic        stamofu_commit_valid;
        rob_ref_t    stamofu_commit;
    } drive_t;

    // sst_action 1 steps the pointer, 2 steps it only on a hit
    typedef struct packed {
        rob_ref_t   upd;
        logic       fresh;
        logic [1:0] sst_action;
    } expect_t;

    logic        CLK;
    logic        nRST;
    drive_t      drv;
    logic        rob_update_valid;
    rob_ref_t    rob_update;
    logic        rob_update_ready;

    string       stim_name [$];
    int          stim_mode [$];
    drive_t      stim_drive [$];
    string       exp_name [$];
    expect_t     exp_q [$];

    ssid_t       alloc_model;
    logic [31:0] lcg_state;
    int          last_mode;
    int          cycles = 0;
    int          cycle_limit;

    ssu_top #(
        .INPUT_ENTRIES(INPUT_ENTRIES),
        .FUNNEL_ENTRIES(FUNNEL_ENTRIES)
    ) dut_i (
        .CLK(CLK),
        .nRST(nRST),
        .ldu_cam_valid(drv.ldu_cam_valid),
        .ldu_cam(drv.ldu_cam),
        .stamofu_cam_valid(drv.stamofu_cam_valid),
        .stamofu_cam(drv.stamofu_cam),
        .ldu_commit_valid(drv.ldu_commit_valid),
        .ldu_commit(drv.ldu_commit),
        .stamofu_commit_valid(drv.stamofu_commit_valid),
        .stamofu_commit(drv.stamofu_commit),
        .rob_update_valid(rob_update_valid),
        .rob_update(rob_update),
        .rob_update_ready(rob_update_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
            fail_now($sformatf("timed out after %0d cycles with updates still missing", cycles));
    end

    // ------------------------------------------------------------------------
    // helpers

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic rob_ref_t make_rob_ref(input int conf, input int ssid, input int rob);
        rob_ref_t r;
        r.mdp.conf  = conf_e'(conf[1:0]);
        r.mdp.ssid  = ssid[SSID_WIDTH-1:0];
        r.rob_index = rob[ROB_INDEX_WIDTH-1:0];
        return r;
    endfunction

    task automatic check_rob_update(input string test, input rob_ref_t expected,
                                    input rob_ref_t actual);
        if (actual !== expected)
            fail_now({$sformatf("Mismatch in %s: expected conf %0d ssid %0d rob %0d,", test,
                                expected.mdp.conf, expected.mdp.ssid, expected.rob_index),
                      $sformatf(" actual conf %0d ssid %0d rob %0d",
                                actual.mdp.conf, actual.mdp.ssid, actual.rob_index)});
    endtask

    task automatic load_testdata();
        int      fd;
        int      n;
        string   line;
        string   kind;
        string   name;
        int      f [23];
        drive_t  d;
        expect_t e;
        fd = $fopen("bench/ssu_testdata.txt", "r");
        if (fd == 0) begin
            fail_now("could not open the test data file bench/ssu_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#")
                    continue;
                n = $sscanf(line, "%s", kind);
                if (kind == "S") begin
                    n = $sscanf(line,
                        "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        kind, name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                        f[18], f[19], f[20], f[21], f[22]);
                    if (n != 25) begin
                        fail_now($sformatf("malformed stimulus line in test data: %s", line));
                    end else begin
                        d.ldu_cam_valid        = f[1][0];
                        d.ldu_cam.ld           = make_rob_ref(f[2], f[3], f[4]);
                        d.ldu_cam.st           = make_rob_ref(f[5], f[6], f[7]);
                        d.stamofu_cam_valid    = f[8][0];
                        d.stamofu_cam.ld       = make_rob_ref(f[9], f[10], f[11]);
                        d.stamofu_cam.st       = make_rob_ref(f[12], f[13], f[14]);
                        d.ldu_commit_valid     = f[15][0];
                        d.ldu_commit           = make_rob_ref(f[16], f[17], f[18]);
                        d.stamofu_commit_valid = f[19][0];
                        d.stamofu_commit       = make_rob_ref(f[20], f[21], f[22]);
                        stim_name.push_back(name);
                        stim_mode.push_back(f[0]);
                        stim_drive.push_back(d);
                    end
                end else if (kind == "E") begin
                    n = $sscanf(line, "%s %s %h %h %h %h %h", kind, name,
                                f[0], f[1], f[2], f[3], f[4]);
                    if (n != 7) begin
                        fail_now($sformatf("malformed expected line in test data: %s", line));
                    end else begin
                        e.upd        = make_rob_ref(f[0], f[1], f[2]);
                        e.fresh      = f[3][0];
                        e.sst_action = f[4][1:0];
                        exp_name.push_back(name);
                        exp_q.push_back(e);
                    end
                end else begin
                    fail_now($sformatf("unknown line kind in test data: %s", line));
                end
            end
            $fclose(fd);
        end
    endtask

    // accepted transfer at the coming edge, outputs are register driven
    task automatic take_rob_transfer();
        expect_t  e;
        rob_ref_t want;
        string    test;
        if (rob_update_valid && rob_update_ready) begin
            if (exp_q.size() == 0) begin
                fail_now("the DUT sent a ROB update while none was expected");
            end else begin
                e    = exp_q.pop_front();
                test = exp_name.pop_front();
                want = e.upd;
                if (e.fresh)
                    want.mdp.ssid = alloc_model;
                check_rob_update(test, want, rob_update);
                if (e.sst_action == 2'd1 ||
                    (e.sst_action == 2'd2 && want.mdp.ssid == alloc_model))
                    alloc_model = alloc_model + 1'b1;
            end
        end
    endtask

    task automatic drive_cycle(input drive_t d, input int mode);
        @(negedge CLK);
        drv = d;
        case (mode)
            0:       rob_update_ready = 1'b0;
            1:       rob_update_ready = 1'b1;
            default: begin
                lcg_state        = lcg_next(lcg_state);
                rob_update_ready = lcg_state[31];
            end
        endcase
        take_rob_transfer();
    endtask

    // idle until the test just run is flushed, then a quiet window
    task automatic drain_test(input string done_name);
        int mode;
        mode = (last_mode == 2) ? 2 : 1;
        while (exp_q.size() != 0 && exp_name[0] == done_name)
            drive_cycle('0, mode);
        repeat (SETTLE_CYCLES) drive_cycle('0, mode);
    endtask

    // ------------------------------------------------------------------------
    // main sequence

    initial begin
        int i;
        drv              = '0;
        nRST             = 1'b0;
        rob_update_ready = 1'b0;
        alloc_model      = '0;
        lcg_state        = LCG_SEED;
        last_mode        = 1;
        cycle_limit      = 200;

        load_testdata();
        cycle_limit = 40 * stim_drive.size() + 200;

        repeat (5) @(negedge CLK);
        nRST = 1'b1;

        for (i = 0; i < stim_drive.size(); i++) begin
            if (i > 0 && stim_name[i] != stim_name[i-1])
                drain_test(stim_name[i-1]);
            drive_cycle(stim_drive[i], stim_mode[i]);
            last_mode = stim_mode[i];
        end
        drain_test(stim_name[stim_name.size()-1]);

        if (exp_q.size() != 0) begin
            fail_now($sformatf("%0d expected ROB updates never arrived", exp_q.size()));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
verilog/ssu_pkg.sv
verilog/update_cb.sv
verilog/update_arbiter.sv
verilog/funnel_queue.sv
verilog/mdp_resolver.sv
verilog/store_set_table.sv
verilog/ssu_top.sv
bench/ssu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ssu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/ssu_testdata.txt
# S name ready(0 low, 1 high, 2 lcg) ldu_cam(v ld:conf ssid rob st:conf ssid rob) stamofu_cam(same)
#   ldu_commit(v conf ssid rob) stamofu_commit(v conf ssid rob); all hex, one line per cycle
# E name conf ssid rob fresh(ssid from alloc pointer) table(0 none, 1 alloc, 2 touch)
S both_pred 1 1 1 05 10 2 09 11 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
E both_pred 3 09 10 0 0
E both_pred 3 09 11 0 2
S fresh_ids 1 1 0 00 20 0 00 21 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S fresh_ids 1 1 0 00 22 0 00 23 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S fresh_ids 1 1 2 02 24 0 00 25 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S fresh_ids 1 1 0 00 26 0 00 27 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
E fresh_ids 3 00 20 1 0
E fresh_ids 3 00 21 1 1
E fresh_ids 3 00 22 1 0
E fresh_ids 3 00 23 1 1
E fresh_ids 3 02 24 0 0
E fresh_ids 3 02 25 0 2
E fresh_ids 3 00 26 1 0
E fresh_ids 3 00 27 1 1
S commit_decay 1 0 0 00 00 0 00 00 0 0 00 00 0 00 00 1 3 07 30 1 2 08 31
S commit_decay 1 0 0 00 00 0 00 00 0 0 00 00 0 00 00 1 1 0b 32 0 0 00 00
E commit_decay 1 07 30 0 0
E commit_decay 0 08 31 0 0
E commit_decay 0 0b 32 0 0
S filtered 1 1 3 0e 40 3 0e 41 0 0 00 00 0 00 00 1 0 01 42 0 0 00 00
S priority 1 1 1 11 50 1 12 51 1 0 00 52 2 13 53 1 3 14 54 1 3 15 55
E priority 3 12 50 0 0
E priority 3 12 51 0 2
E priority 3 13 52 0 0
E priority 3 13 53 0 2
E priority 1 14 54 0 0
E priority 1 15 55 0 0
S overflow 0 1 1 20 60 1 21 61 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S overflow 0 1 1 20 62 1 22 63 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S overflow 0 1 1 20 64 1 23 65 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S overflow 0 1 1 20 66 1 24 67 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S overflow 0 1 1 20 68 1 25 69 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
E overflow 3 21 60 0 0
E overflow 3 21 61 0 2
E overflow 3 22 62 0 0
E overflow 3 22 63 0 2
E overflow 3 24 66 0 0
E overflow 3 24 67 0 2
E overflow 3 25 68 0 0
E overflow 3 25 69 0 2
S random_ready 2 1 2 30 70 1 31 71 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S random_ready 2 1 2 30 72 1 32 73 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
S random_ready 2 1 2 30 74 1 33 75 0 0 00 00 0 00 00 0 0 00 00 0 0 00 00
E random_ready 3 31 70 0 0
E random_ready 3 31 71 0 2
E random_ready 3 32 72 0 0
E random_ready 3 32 73 0 2
E random_ready 3 33 74 0 0
E random_ready 3 33 75 0 2
